// File: ex2_cfg.svh
`ifndef EX2_CFG_SVH
`define EX2_CFG_SVH

// micro-op layout
`define WIDTH_UOP   8
`define UOP_COND    3:0
`define COND_REM    0       // div: remainder instead of quotient
`define COND_STORE  2       // mem: set for store
`define INS_CSR     4
`define INS_DIV     5
`define INS_MEM     6

// exception codes
`define EXP_PIL     7'h01
`define EXP_PIS     7'h02
`define EXP_PIF     7'h03
`define EXP_PME     7'h04
`define EXP_PPI     7'h07
`define EXP_ADEF    7'h08
`define EXP_ALE     7'h09
`define EXP_SYS     7'h0B   // syscall, no badv or vppn update
`define EXP_TLBR    7'h3F

// csr numbers
`define CSR_ESTAT   14'h005
`define CSR_ERA     14'h006
`define CSR_BADV    14'h007
`define CSR_TLBEHI  14'h011

// iterative divider, one quotient bit per step
`define DIV_STEPS   32

`endif

// File: ex2_pkg.sv
`default_nettype none

`include "ex2_cfg.svh"

package ex2_pkg;

    typedef logic [31:0]            word_t;     // data, pc, address
    typedef logic [5:0]             reg_idx_t;
    typedef logic [`WIDTH_UOP-1:0]  uop_t;
    typedef logic [6:0]             ecode_t;
    typedef logic [18:0]            vppn_t;
    typedef logic [13:0]            csr_num_t;

    // issue-group controller
    typedef enum logic {
        GRP_IDLE,
        GRP_WAIT
    } grp_state_e;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_e;

    // wishbone read master
    typedef enum logic {
        WBM_IDLE,
        WBM_BUS
    } wbm_state_e;

endpackage

`default_nettype wire

// File: ex2_wb.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex2_cfg.svh"

module ex2_wb
    import ex2_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       aresetn,
    input  wire logic       issue_valid,
    output logic            ex2_ready,
    input  wire word_t      pc0,
    input  wire word_t      pc1,
    input  wire word_t      inst0,
    input  wire word_t      inst1,
    input  wire uop_t       uop0,
    input  wire uop_t       uop1,
    input  wire word_t      result0,
    input  wire word_t      result1,
    input  wire logic       result0_valid,
    input  wire logic       result1_valid,
    input  wire reg_idx_t   rd0,
    input  wire reg_idx_t   rd1,
    input  wire word_t      quotient,
    input  wire word_t      remainder,
    input  wire logic       div_ready,
    output logic            div_start,
    input  wire word_t      dcache_data,
    input  wire logic       dcache_ready,
    output logic            mem_req,
    input  wire word_t      csr_data,
    input  wire logic       csr_ready,
    output logic            csr_req,
    output word_t           wb_data0,
    output word_t           wb_data1,
    output reg_idx_t        wb_rd0,
    output reg_idx_t        wb_rd1,
    output logic            wb_we0,
    output logic            wb_we1,
    output word_t           debug0_pc,
    output word_t           debug0_inst,
    output word_t           debug1_pc,
    output word_t           debug1_inst,
    input  wire logic       exception_flag_in,
    input  wire ecode_t     ecode_in,
    input  wire word_t      badv_in,
    input  wire word_t      era_in,
    output ecode_t          ecode_out,
    output logic            exception_flag_out,
    output logic            tlb_exception,
    output word_t           badv_out,
    output logic            wen_badv,
    output word_t           era_out,
    output logic            wen_era,
    output vppn_t           vppn_out,
    output logic            wen_vppn
);

    grp_state_e state;
    logic [3:0] cond0;
    logic [3:0] cond1;
    logic       csr0;
    logic       div0;
    logic       ld0;
    logic       div1;
    logic       ld1;
    logic       need_div;
    logic       need_ld;
    logic       need_long;
    logic       long_done;
    logic       launch;
    logic       accept;
    logic       lane_we0;
    logic       lane_we1;
    logic       set_badv;
    logic       set_vppn;
    word_t      sel0;
    word_t      sel1;

    assign cond0 = uop0[`UOP_COND];
    assign cond1 = uop1[`UOP_COND];

    // lane kinds, an ALU result always wins
    assign csr0 = !result0_valid && uop0[`INS_CSR];
    assign div0 = !result0_valid && !uop0[`INS_CSR] && uop0[`INS_DIV];
    assign ld0  = !result0_valid && !uop0[`INS_CSR] && !uop0[`INS_DIV]
                  && uop0[`INS_MEM] && !cond0[`COND_STORE];
    assign div1 = !result1_valid && uop1[`INS_DIV];       // no csr on lane 1
    assign ld1  = !result1_valid && !uop1[`INS_DIV]
                  && uop1[`INS_MEM] && !cond1[`COND_STORE];

    assign need_div  = div0 || div1;
    assign need_ld   = ld0 || ld1;
    assign need_long = csr0 || need_div || need_ld;
    assign long_done = (csr0 && csr_ready) || (need_div && div_ready)
                       || (need_ld && dcache_ready);

    assign launch    = issue_valid && need_long && (state == GRP_IDLE);
    assign div_start = launch && need_div;
    assign mem_req   = launch && need_ld;
    assign csr_req   = launch && csr0;

    assign ex2_ready = !need_long || ((state == GRP_WAIT) && long_done);
    assign accept    = issue_valid && ex2_ready;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= GRP_IDLE;
        end else begin
            case (state)
                GRP_IDLE: if (launch) state <= GRP_WAIT;
                GRP_WAIT: if (long_done) state <= GRP_IDLE;   // done pulse is the accept
                default:  state <= GRP_IDLE;
            endcase
        end
    end

    always_comb begin
        sel0 = result0;
        if (csr0) begin
            sel0 = csr_data;
        end else if (div0) begin
            sel0 = cond0[`COND_REM] ? remainder : quotient;
        end else if (ld0) begin
            sel0 = dcache_data;
        end
    end

    always_comb begin
        sel1 = result1;
        if (div1) begin
            sel1 = cond1[`COND_REM] ? remainder : quotient;
        end else if (ld1) begin
            sel1 = dcache_data;
        end
    end

    assign lane_we0 = result0_valid || csr0 || div0 || ld0;   // stores fall out here
    assign lane_we1 = result1_valid || div1 || ld1;

    assign set_badv = ecode_in inside {`EXP_PIL, `EXP_PIS, `EXP_PIF, `EXP_PME,
                                       `EXP_PPI, `EXP_ADEF, `EXP_ALE, `EXP_TLBR};
    assign set_vppn = ecode_in inside {`EXP_PIL, `EXP_PIS, `EXP_PIF, `EXP_PME,
                                       `EXP_PPI, `EXP_TLBR};

    // one-cycle strobes
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wb_we0             <= 1'b0;
            wb_we1             <= 1'b0;
            exception_flag_out <= 1'b0;
            tlb_exception      <= 1'b0;
            wen_badv           <= 1'b0;
            wen_era            <= 1'b0;
            wen_vppn           <= 1'b0;
        end else begin
            wb_we0             <= accept && lane_we0 && !exception_flag_in;
            wb_we1             <= accept && lane_we1 && !exception_flag_in;
            exception_flag_out <= accept && exception_flag_in;
            tlb_exception      <= accept && exception_flag_in && (ecode_in == `EXP_TLBR);
            wen_badv           <= accept && exception_flag_in && set_badv;
            wen_era            <= accept && exception_flag_in;
            wen_vppn           <= accept && exception_flag_in && set_vppn;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_data0    <= sel0;
            wb_data1    <= sel1;
            wb_rd0      <= rd0;
            wb_rd1      <= rd1;
            debug0_pc   <= pc0;
            debug0_inst <= inst0;
            debug1_pc   <= pc1;
            debug1_inst <= inst1;
            ecode_out   <= ecode_in;
            badv_out    <= badv_in;
            era_out     <= era_in;
            vppn_out    <= badv_in[18:0];
        end
    end

endmodule

`default_nettype wire

// File: iter_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex2_cfg.svh"

module iter_divider
    import ex2_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   aresetn,
    input  wire logic   div_start,
    input  wire word_t  div_dividend,
    input  wire word_t  div_divisor,
    output word_t       quotient,
    output word_t       remainder,
    output logic        div_ready
);

    localparam int unsigned CNT_W = $clog2(`DIV_STEPS);

    div_state_e         state;
    logic [CNT_W-1:0]   step;
    word_t              divisor_q;
    logic [32:0]        partial;
    logic [33:0]        diff;

    // quotient doubles as the dividend shift register
    assign partial = {remainder, quotient[31]};
    assign diff    = {1'b0, partial} - {2'b00, divisor_q};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else if (div_start) begin
            state <= DIV_RUN;
            step  <= '0;
        end else begin
            case (state)
                DIV_RUN: begin
                    step <= step + 1'b1;
                    if (step == CNT_W'(`DIV_STEPS - 1)) begin
                        state <= DIV_DONE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            divisor_q <= div_divisor;
            quotient  <= div_dividend;
            remainder <= '0;
        end else if (state == DIV_RUN) begin
            if (diff[33]) begin                 // borrow, restore
                remainder <= partial[31:0];
                quotient  <= {quotient[30:0], 1'b0};
            end else begin
                remainder <= diff[31:0];
                quotient  <= {quotient[30:0], 1'b1};
            end
        end
    end

    // divide by zero falls out as all ones / dividend
    assign div_ready = (state == DIV_DONE);

endmodule

`default_nettype wire

// File: dcache_port.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_port
    import ex2_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   aresetn,
    input  wire logic   mem_req,
    input  wire word_t  mem_addr,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output word_t       wb_adr,
    input  wire word_t  wb_dat_i,
    input  wire logic   wb_ack,
    output word_t       dcache_data,
    output logic        dcache_ready
);

    wbm_state_e state;

    assign wb_cyc = (state == WBM_BUS);
    assign wb_stb = (state == WBM_BUS);
    assign wb_we  = 1'b0;                   // loads only

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state        <= WBM_IDLE;
            dcache_ready <= 1'b0;
        end else begin
            dcache_ready <= 1'b0;
            case (state)
                WBM_IDLE: if (mem_req) state <= WBM_BUS;
                WBM_BUS: begin
                    if (wb_ack) begin       // slave may hold ack off
                        state        <= WBM_IDLE;
                        dcache_ready <= 1'b1;
                    end
                end
                default: state <= WBM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req && (state == WBM_IDLE)) begin
            wb_adr <= mem_addr;
        end
        if (wb_ack && (state == WBM_BUS)) begin
            dcache_data <= wb_dat_i;
        end
    end

endmodule

`default_nettype wire

// File: csr_excp_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex2_cfg.svh"

module csr_excp_file
    import ex2_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       aresetn,
    input  wire logic       csr_req,
    input  wire csr_num_t   csr_num,
    output word_t           csr_data,
    output logic            csr_ready,
    input  wire ecode_t     ecode_out,
    input  wire logic       exception_flag_out,
    input  wire word_t      badv_out,
    input  wire logic       wen_badv,
    input  wire word_t      era_out,
    input  wire logic       wen_era,
    input  wire vppn_t      vppn_out,
    input  wire logic       wen_vppn
);

    ecode_t estat_ecode;
    word_t  era_q;
    word_t  badv_q;
    vppn_t  tlbehi_vppn;
    word_t  rd_val;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            estat_ecode <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            tlbehi_vppn <= '0;
        end else begin
            if (exception_flag_out) estat_ecode <= ecode_out;
            if (wen_era)            era_q       <= era_out;
            if (wen_badv)           badv_q      <= badv_out;
            if (wen_vppn)           tlbehi_vppn <= vppn_out;
        end
    end

    always_comb begin
        case (csr_num)
            `CSR_ESTAT:  rd_val = {9'd0, estat_ecode, 16'd0};   // ecode at bit 16
            `CSR_ERA:    rd_val = era_q;
            `CSR_BADV:   rd_val = badv_q;
            `CSR_TLBEHI: rd_val = {tlbehi_vppn, 13'd0};
            default:     rd_val = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            csr_ready <= 1'b0;
        end else begin
            csr_ready <= csr_req;
        end
    end

    always_ff @(posedge clk) begin
        if (csr_req) csr_data <= rd_val;    // held until next read
    end

endmodule

`default_nettype wire

// File: ex2_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module ex2_subsys
    import ex2_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       aresetn,
    input  wire logic       issue_valid,
    output logic            ex2_ready,
    input  wire word_t      pc0,
    input  wire word_t      pc1,
    input  wire word_t      inst0,
    input  wire word_t      inst1,
    input  wire uop_t       uop0,
    input  wire uop_t       uop1,
    input  wire word_t      result0,
    input  wire word_t      result1,
    input  wire logic       result0_valid,
    input  wire logic       result1_valid,
    input  wire reg_idx_t   rd0,
    input  wire reg_idx_t   rd1,
    input  wire word_t      div_dividend,
    input  wire word_t      div_divisor,
    input  wire word_t      mem_addr,
    input  wire csr_num_t   csr_num,
    input  wire logic       exception_flag_in,
    input  wire ecode_t     ecode_in,
    input  wire word_t      badv_in,
    input  wire word_t      era_in,
    output word_t           wb_data0,
    output word_t           wb_data1,
    output reg_idx_t        wb_rd0,
    output reg_idx_t        wb_rd1,
    output logic            wb_we0,
    output logic            wb_we1,
    output word_t           debug0_pc,
    output word_t           debug0_inst,
    output word_t           debug1_pc,
    output word_t           debug1_inst,
    output ecode_t          ecode_out,
    output logic            exception_flag_out,
    output logic            tlb_exception,
    output word_t           badv_out,
    output logic            wen_badv,
    output word_t           era_out,
    output logic            wen_era,
    output vppn_t           vppn_out,
    output logic            wen_vppn,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output word_t           wb_adr,
    input  wire word_t      wb_dat_i,
    input  wire logic       wb_ack
);

    wire logic  div_start;
    wire logic  mem_req;
    wire logic  csr_req;
    wire word_t quotient;
    wire word_t remainder;
    wire logic  div_ready;
    wire word_t dcache_data;
    wire logic  dcache_ready;
    wire word_t csr_data;
    wire logic  csr_ready;

    ex2_wb u_ex2_wb (.*);

    iter_divider u_divider (
        .clk          (clk),
        .aresetn      (aresetn),
        .div_start    (div_start),
        .div_dividend (div_dividend),
        .div_divisor  (div_divisor),
        .quotient     (quotient),
        .remainder    (remainder),
        .div_ready    (div_ready)
    );

    dcache_port u_dcache_port (.*);

    // exception csrs fed from the registered exception outputs
    csr_excp_file u_csr_file (.*);

endmodule

`default_nettype wire

// File: ex2_subsys_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ex2_subsys_properties
    import ex2_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   aresetn,
    input  wire logic   div_start,
    input  wire logic   mem_req,
    input  wire logic   csr_req,
    input  wire logic   wb_we0,
    input  wire logic   wb_we1,
    input  wire logic   wb_cyc,
    input  wire logic   wb_stb,
    input  wire word_t  wb_adr,
    input  wire logic   wb_ack
);

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!aresetn)
        wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // classic cycle held until the slave answers
    bus_held: assert property (@(posedge clk) disable iff (!aresetn)
        (wb_cyc && wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_adr)))
        else $error("wishbone request changed before ack");

    one_launch: assert property (@(posedge clk) disable iff (!aresetn)
        $onehot0({div_start, mem_req, csr_req}))
        else $error("more than one long operation launched");

    quiet_after_reset: assert property (@(posedge clk)
        !aresetn |=> (!wb_we0 && !wb_we1 && !wb_cyc && !wb_stb))
        else $error("write enable or bus request high right after reset");

endmodule

bind ex2_wb ex2_subsys_properties u_wb_props (
    .clk       (clk),
    .aresetn   (aresetn),
    .div_start (div_start),
    .mem_req   (mem_req),
    .csr_req   (csr_req),
    .wb_we0    (wb_we0),
    .wb_we1    (wb_we1),
    .wb_cyc    (1'b0),
    .wb_stb    (1'b0),
    .wb_adr    (32'd0),
    .wb_ack    (1'b0)
);

bind dcache_port ex2_subsys_properties u_bus_props (
    .clk       (clk),
    .aresetn   (aresetn),
    .div_start (1'b0),
    .mem_req   (mem_req),
    .csr_req   (1'b0),
    .wb_we0    (1'b0),
    .wb_we1    (1'b0),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_adr    (wb_adr),
    .wb_ack    (wb_ack)
);

`default_nettype wire

// File: tb_ex2_subsys.sv
`timescale 1ns/1ps
`default_nettype none

`include "ex2_cfg.svh"

module tb_ex2_subsys
    import ex2_pkg::*;
();

    localparam int    NROWS      = 27;
    localparam int    MAX_CYCLES = NROWS * 60;
    localparam word_t LOAD_MASK  = 32'h5A5A_0000;
    localparam word_t TLBR_BADV  = 32'h1234_5678;
    localparam word_t TLBR_ERA   = 32'h1C00_0100;
    localparam word_t ADEF_BADV  = 32'hDEAD_BEE2;
    localparam word_t ADEF_ERA   = 32'h1C00_0200;
    localparam word_t SYS_BADV   = 32'h5555_0000;
    localparam word_t SYS_ERA    = 32'h1C00_0300;

    logic       clk;
    logic       aresetn;
    logic       issue_valid;
    logic       ex2_ready;
    word_t      pc0;
    word_t      pc1;
    word_t      inst0;
    word_t      inst1;
    uop_t       uop0;
    uop_t       uop1;
    word_t      result0;
    word_t      result1;
    logic       result0_valid;
    logic       result1_valid;
    reg_idx_t   rd0;
    reg_idx_t   rd1;
    word_t      div_dividend;
    word_t      div_divisor;
    word_t      mem_addr;
    csr_num_t   csr_num;
    logic       exception_flag_in;
    ecode_t     ecode_in;
    word_t      badv_in;
    word_t      era_in;
    word_t      wb_data0;
    word_t      wb_data1;
    reg_idx_t   wb_rd0;
    reg_idx_t   wb_rd1;
    logic       wb_we0;
    logic       wb_we1;
    word_t      debug0_pc;
    word_t      debug0_inst;
    word_t      debug1_pc;
    word_t      debug1_inst;
    ecode_t     ecode_out;
    logic       exception_flag_out;
    logic       tlb_exception;
    word_t      badv_out;
    logic       wen_badv;
    word_t      era_out;
    logic       wen_era;
    vppn_t      vppn_out;
    logic       wen_vppn;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    word_t      wb_adr;
    word_t      wb_dat_i = '0;
    logic       wb_ack = 1'b0;

    // stimulus table
    string      t_name [NROWS];
    uop_t       t_uop0 [NROWS];
    uop_t       t_uop1 [NROWS];
    word_t      t_res0 [NROWS];
    word_t      t_res1 [NROWS];
    logic       t_rv0 [NROWS];
    logic       t_rv1 [NROWS];
    reg_idx_t   t_rd0 [NROWS];
    reg_idx_t   t_rd1 [NROWS];
    word_t      t_dvd [NROWS];
    word_t      t_dvs [NROWS];
    word_t      t_addr [NROWS];
    csr_num_t   t_csr [NROWS];
    logic       t_exc [NROWS];
    ecode_t     t_ecode [NROWS];
    word_t      t_badv [NROWS];
    word_t      t_era [NROWS];
    // expected values
    word_t      e_d0 [NROWS];
    word_t      e_d1 [NROWS];
    logic       e_we0 [NROWS];
    logic       e_we1 [NROWS];
    logic       e_tlb [NROWS];
    logic       e_wbadv [NROWS];
    logic       e_wvppn [NROWS];

    int          nrows;
    int          last;
    string       cur_name;
    logic        acc_q;
    logic [15:0] lfsr = 16'd21677;
    logic [1:0]  ack_wait;

    ex2_subsys DUT (.*);

    always #50 clk = ~clk;

    // group taken on this edge is seen by the checker at the next falling edge
    always @(posedge clk) begin
        acc_q <= issue_valid && ex2_ready;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // wishbone slave acks after 0 to 3 idle cycles
    always @(negedge clk) begin : wb_slave
        logic [1:0] pick;
        if (!aresetn) begin
            wb_ack   <= 1'b0;
            ack_wait <= 2'd0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
            pick = {1'b0, lfsr[0]};
            lfsr = lfsr_step(lfsr);
            pick = {pick[0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
            ack_wait <= pick;
        end else if (wb_cyc && wb_stb) begin
            check_bit("wb_we during load", 1'b0, wb_we);
            if (ack_wait == 2'd0) begin
                wb_ack   <= 1'b1;
                wb_dat_i <= wb_adr ^ LOAD_MASK;
            end else begin
                ack_wait <= ack_wait - 2'd1;
            end
        end
    end

    task automatic check_word(input string what, input word_t exp, input word_t act);
        assert (act === exp) else begin
            $display("error %s %s expected %h actual %h", cur_name, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("error %s %s expected %b actual %b", cur_name, what, exp, act);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    // default row is an ALU pair
    task automatic new_row(input string name);
        last = nrows;
        nrows = nrows + 1;
        t_name[last]  = name;
        t_uop0[last]  = '0;
        t_uop1[last]  = '0;
        t_res0[last]  = 32'hA000_0000 | word_t'(last);
        t_res1[last]  = 32'hB000_0000 | word_t'(last);
        t_rv0[last]   = 1'b1;
        t_rv1[last]   = 1'b1;
        t_rd0[last]   = reg_idx_t'(2 * last + 1);
        t_rd1[last]   = reg_idx_t'(2 * last + 2);
        t_dvd[last]   = '0;
        t_dvs[last]   = '0;
        t_addr[last]  = '0;
        t_csr[last]   = '0;
        t_exc[last]   = 1'b0;
        t_ecode[last] = '0;
        t_badv[last]  = '0;
        t_era[last]   = '0;
        e_d0[last]    = t_res0[last];
        e_d1[last]    = t_res1[last];
        e_we0[last]   = 1'b1;
        e_we1[last]   = 1'b1;
        e_tlb[last]   = 1'b0;
        e_wbadv[last] = 1'b0;
        e_wvppn[last] = 1'b0;
    endtask

    task automatic row_div(input string name, input int lane, input int rem,
                           input word_t dvd, input word_t dvs);
        word_t q;
        word_t r;
        new_row(name);
        q = (dvs == 32'd0) ? 32'hFFFF_FFFF : dvd / dvs;
        r = (dvs == 32'd0) ? dvd : dvd % dvs;
        t_dvd[last] = dvd;
        t_dvs[last] = dvs;
        if (lane == 0) begin
            t_uop0[last] = uop_t'((1 << `INS_DIV) | (rem << `COND_REM));
            t_rv0[last]  = 1'b0;
            e_d0[last]   = (rem != 0) ? r : q;
        end else begin
            t_uop1[last] = uop_t'((1 << `INS_DIV) | (rem << `COND_REM));
            t_rv1[last]  = 1'b0;
            e_d1[last]   = (rem != 0) ? r : q;
        end
    endtask

    task automatic row_mem(input string name, input int lane, input int store,
                           input word_t addr);
        new_row(name);
        t_addr[last] = addr;
        if (lane == 0) begin
            t_uop0[last] = uop_t'((1 << `INS_MEM) | (store << `COND_STORE));
            t_rv0[last]  = 1'b0;
            e_d0[last]   = addr ^ LOAD_MASK;
            e_we0[last]  = (store == 0);
        end else begin
            t_uop1[last] = uop_t'((1 << `INS_MEM) | (store << `COND_STORE));
            t_rv1[last]  = 1'b0;
            e_d1[last]   = addr ^ LOAD_MASK;
            e_we1[last]  = (store == 0);
        end
    endtask

    task automatic row_exc(input string name, input ecode_t code, input word_t badv,
                           input word_t era, input logic tlb, input logic wbadv,
                           input logic wvppn);
        new_row(name);
        t_exc[last]   = 1'b1;
        t_ecode[last] = code;
        t_badv[last]  = badv;
        t_era[last]   = era;
        e_we0[last]   = 1'b0;
        e_we1[last]   = 1'b0;
        e_tlb[last]   = tlb;
        e_wbadv[last] = wbadv;
        e_wvppn[last] = wvppn;
    endtask

    task automatic row_csr(input string name, input csr_num_t num, input word_t exp);
        new_row(name);
        t_uop0[last] = uop_t'(1 << `INS_CSR);
        t_rv0[last]  = 1'b0;
        t_csr[last]  = num;
        e_d0[last]   = exp;
    endtask

    task automatic build_table();
        new_row("alu_pair");
        row_div("div_quot_lane0", 0, 0, 32'd1000, 32'd7);
        row_div("div_rem_lane1", 1, 1, 32'hFFFF_FFF1, 32'd16);
        row_div("div_quot_lane1", 1, 0, 32'h8000_0000, 32'd3);
        row_div("div_zero_quot", 0, 0, 32'hCAFE_0001, 32'd0);
        row_div("div_zero_rem", 1, 1, 32'h1234_5678, 32'd0);
        row_mem("load_lane0_a", 0, 0, 32'h0000_1010);
        row_mem("load_lane1_a", 1, 0, 32'h0000_2ABC);
        row_mem("load_lane0_b", 0, 0, 32'h8000_0FF0);
        row_mem("load_lane1_b", 1, 0, 32'h0001_0004);
        row_mem("load_lane0_c", 0, 0, 32'h00C0_0020);
        row_mem("store_lane0", 0, 1, 32'h0000_3000);
        row_mem("store_lane1", 1, 1, 32'h0000_3004);
        row_exc("exc_tlbr", `EXP_TLBR, TLBR_BADV, TLBR_ERA, 1'b1, 1'b1, 1'b1);
        new_row("gap_after_tlbr");  // csr file lags the exception by one edge
        row_csr("csr_tlbehi", `CSR_TLBEHI, {TLBR_BADV[18:0], 13'd0});
        row_csr("csr_era_tlbr", `CSR_ERA, TLBR_ERA);
        row_exc("exc_adef", `EXP_ADEF, ADEF_BADV, ADEF_ERA, 1'b0, 1'b1, 1'b0);
        new_row("gap_after_adef");
        row_csr("csr_badv", `CSR_BADV, ADEF_BADV);
        row_csr("csr_tlbehi_kept", `CSR_TLBEHI, {TLBR_BADV[18:0], 13'd0});
        row_exc("exc_syscall", `EXP_SYS, SYS_BADV, SYS_ERA, 1'b0, 1'b0, 1'b0);
        new_row("gap_after_syscall");
        row_csr("csr_era", `CSR_ERA, SYS_ERA);
        row_csr("csr_badv_kept", `CSR_BADV, ADEF_BADV);
        row_csr("csr_estat", `CSR_ESTAT, {9'd0, `EXP_SYS, 16'd0});
        row_csr("csr_unknown", 14'h3FF, 32'd0);
    endtask

    task automatic drive_row(input int i);
        pc0               = 32'h1C00_0000 + word_t'(8 * i);
        pc1               = pc0 + 32'd4;
        inst0             = 32'h0280_0000 | word_t'(i);
        inst1             = 32'h0290_0000 | word_t'(i);
        uop0              = t_uop0[i];
        uop1              = t_uop1[i];
        result0           = t_res0[i];
        result1           = t_res1[i];
        result0_valid     = t_rv0[i];
        result1_valid     = t_rv1[i];
        rd0               = t_rd0[i];
        rd1               = t_rd1[i];
        div_dividend      = t_dvd[i];
        div_divisor       = t_dvs[i];
        mem_addr          = t_addr[i];
        csr_num           = t_csr[i];
        exception_flag_in = t_exc[i];
        ecode_in          = t_ecode[i];
        badv_in           = t_badv[i];
        era_in            = t_era[i];
        issue_valid       = 1'b1;
    endtask

    task automatic check_idle();
        check_bit("wb_we0 without accept", 1'b0, wb_we0);
        check_bit("wb_we1 without accept", 1'b0, wb_we1);
        check_bit("exception_flag_out without accept", 1'b0, exception_flag_out);
    endtask

    task automatic check_row(input int i);
        cur_name = t_name[i];
        check_bit("wb_we0", e_we0[i], wb_we0);
        check_bit("wb_we1", e_we1[i], wb_we1);
        if (e_we0[i]) begin
            check_word("wb_data0", e_d0[i], wb_data0);
            check_word("wb_rd0", word_t'(t_rd0[i]), word_t'(wb_rd0));
        end
        if (e_we1[i]) begin
            check_word("wb_data1", e_d1[i], wb_data1);
            check_word("wb_rd1", word_t'(t_rd1[i]), word_t'(wb_rd1));
        end
        check_word("debug0_pc", 32'h1C00_0000 + word_t'(8 * i), debug0_pc);
        check_word("debug0_inst", 32'h0280_0000 | word_t'(i), debug0_inst);
        check_word("debug1_pc", 32'h1C00_0004 + word_t'(8 * i), debug1_pc);
        check_word("debug1_inst", 32'h0290_0000 | word_t'(i), debug1_inst);
        check_bit("exception_flag_out", t_exc[i], exception_flag_out);
        check_bit("wen_era", t_exc[i], wen_era);
        check_bit("tlb_exception", e_tlb[i], tlb_exception);
        check_bit("wen_badv", e_wbadv[i], wen_badv);
        check_bit("wen_vppn", e_wvppn[i], wen_vppn);
        if (t_exc[i]) begin
            check_word("ecode_out", word_t'(t_ecode[i]), word_t'(ecode_out));
            check_word("era_out", t_era[i], era_out);
            check_word("badv_out", t_badv[i], badv_out);
            check_word("vppn_out", word_t'(t_badv[i][18:0]), word_t'(vppn_out));
        end
    endtask

    initial begin
        clk               = 1'b0;
        aresetn           = 1'b0;
        issue_valid       = 1'b0;
        pc0               = '0;
        pc1               = '0;
        inst0             = '0;
        inst1             = '0;
        uop0              = '0;
        uop1              = '0;
        result0           = '0;
        result1           = '0;
        result0_valid     = 1'b0;
        result1_valid     = 1'b0;
        rd0               = '0;
        rd1               = '0;
        div_dividend      = '0;
        div_divisor       = '0;
        mem_addr          = '0;
        csr_num           = '0;
        exception_flag_in = 1'b0;
        ecode_in          = '0;
        badv_in           = '0;
        era_in            = '0;
        nrows             = 0;
        cur_name          = "reset";
        build_table();
        repeat (3) @(negedge clk);
        aresetn = 1'b1;
        check_bit("wb_we0 after reset", 1'b0, wb_we0);
        check_bit("wb_we1 after reset", 1'b0, wb_we1);
        check_bit("exception_flag_out after reset", 1'b0, exception_flag_out);
        check_bit("wb_cyc after reset", 1'b0, wb_cyc);
        for (int i = 0; i < nrows; i++) begin
            drive_row(i);
            cur_name = t_name[i];
            do begin
                @(negedge clk);
                if (!acc_q) check_idle();
            end while (!acc_q);
            check_row(i);
        end
        issue_valid = 1'b0;
        cur_name = "drain";
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        $display("TEST PASS");
        $finish;
    end

    // bound by the table length
    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("timeout: group %s was not accepted within %0d cycles", cur_name, MAX_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: ex2_subsys.f
+incdir+.
ex2_pkg.sv
ex2_wb.sv
iter_divider.sv
dcache_port.sv
csr_excp_file.sv
ex2_subsys.sv
ex2_subsys_properties.sv
tb_ex2_subsys.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then decide from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ex2_subsys \
    -f ex2_subsys.f -o sim_ex2 || exit 1
./obj_dir/sim_ex2 > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1
grep -q "TEST PASS" sim.log || exit 1
exit 0
